// ==== phold_core.f ====
source/phold_pkg.sv
source/history_pkg.sv
source/history_store.sv
source/history_filter.sv
source/event_fifo.sv
source/phold_sequencer.sv
source/phold_core.sv
bench/phold_core_checker.sv
bench/phold_core_tb.sv

// ==== bench/phold_core_tb.sv ====
`timescale 1ns/1ps

module phold_core_tb;
   import phold_pkg::*;

   localparam int tab_len     = 10;
   localparam int rand_len    = 20;
   localparam int wait_max    = 200;   // Cycles per wait
   localparam int sel_in_ack  = 0;
   localparam int sel_out_req = 1;
   localparam int sel_busy    = 2;

   typedef struct packed {
      logic [2:0]  lp;
      logic [15:0] ev_time;
      logic        ev_type;     // 1 is a cancellation
      logic [15:0] gvt;
      logic [7:0]  rnd;
      logic [5:0]  n_out;       // Expected number of output messages
   } stim_t;

   logic               clk;
   logic               rst_n;
   logic               in_req;
   logic [msg_w-1:0]   in_msg;
   logic [time_w-1:0]  in_gvt;
   logic [rnd_w-1:0]   in_rnd;
   logic               in_ack;
   logic               out_req;
   logic [msg_w-1:0]   out_msg;
   logic               out_ack;
   logic               busy;

   stim_t       stim_tab [0:tab_len-1];
   logic [31:0] hist [0:127];          // Reference history, LP times 16 plus index
   int          hist_cnt [0:7];
   logic [31:0] exp_q [$];
   logic [31:0] lcg_state = 32'h56f1_1b5b;
   int          n_checks = 0;
   int          n_errors = 0;
   bit          timed_out = 0;

   phold_core i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] build_msg(input logic typ, input logic [2:0] lp,
                                             input logic [15:0] t);
      return {12'h000, typ, lp, t};
   endfunction

   function automatic logic probe(input int sel);
      case (sel)
         sel_in_ack:  return in_ack;
         sel_out_req: return out_req;
         default:     return busy;
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic wait_for(input int sel, input logic level, input string what);
      int cycles;
      cycles = 0;
      while (probe(sel) !== level && cycles < wait_max && !timed_out) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (probe(sel) !== level && !timed_out) begin
         timed_out = 1'b1;
         $display("Timeout at %0t ns: waited %0d cycles for %s", $time, wait_max, what);
      end
   endtask

   // Expected outputs and new history of one event
   task automatic predict(input stim_t s);
      logic [31:0] kept [$];
      logic [31:0] rolled [$];
      logic [31:0] e;
      logic [31:0] cancel_m;
      logic [7:0]  gen_off;
      logic        discard;
      logic        pending;
      int          i;
      exp_q.delete();
      discard  = 1'b0;
      pending  = 1'b0;
      cancel_m = '0;
      for (i = 0; i < hist_cnt[s.lp]; i++) begin
         e = hist[s.lp*16 + i];
         if (e[15:0] >= s.gvt) begin           // Older entries are dropped
            if (e[19] != s.ev_type && e[15:0] == s.ev_time && !discard) begin
               discard = 1'b1;
               if (s.ev_type) begin
                  pending  = 1'b1;
                  cancel_m = build_msg(1'b1, e[30:28], e[15:0] + e[27:20]);
               end
            end else if (!s.ev_type && !e[19] && e[15:0] > s.ev_time) begin
               rolled.push_back(e);
            end else begin
               kept.push_back(e);
            end
         end
      end
      gen_off = 8'd10 + {3'b000, s.rnd[4:0]};
      if (!s.ev_type && !discard && kept.size() < 16) begin
         kept.push_back({1'b0, s.rnd[7:5], gen_off, 1'b0, s.lp, s.ev_time});
      end
      hist_cnt[s.lp] = kept.size();
      for (i = 0; i < kept.size(); i++) begin
         hist[s.lp*16 + i] = kept[i];
      end
      if (discard) begin
         exp_q.push_back(pending ? cancel_m : build_msg(1'b1, 3'd0, 16'd0));
      end else if (s.ev_type) begin
         exp_q.push_back(build_msg(1'b1, 3'd0, 16'd0));   // Unmatched cancellation
      end else begin
         exp_q.push_back(build_msg(1'b0, s.rnd[7:5], s.ev_time + gen_off));
      end
      foreach (rolled[k]) begin
         exp_q.push_back(build_msg(1'b1, rolled[k][30:28], rolled[k][15:0] + rolled[k][27:20]));
         exp_q.push_back(build_msg(1'b0, rolled[k][18:16], rolled[k][15:0]));
      end
   endtask

   // Put one event on the input side and raise in_req
   task automatic send_request(input stim_t s);
      in_msg = build_msg(s.ev_type, s.lp, s.ev_time);
      in_gvt = s.gvt;
      in_rnd = s.rnd;
      in_req = 1'b1;
   endtask

   // Rest of the input handshake
   task automatic take_input();
      wait_for(sel_in_ack, 1'b1, "in_ack rising");
      check_value("out_req at input ack", out_req, 32'd0);
      check_value("busy at input ack", busy, 32'd1);
      in_req = 1'b0;
      wait_for(sel_in_ack, 1'b0, "in_ack falling");
   endtask

   // Every expected output with a random ack delay
   task automatic collect_outputs();
      logic [31:0] exp;
      int          delay;
      while (exp_q.size() > 0 && !timed_out) begin
         exp = exp_q.pop_front();
         wait_for(sel_out_req, 1'b1, "out_req rising");
         if (!timed_out) begin
            check_value("output message", out_msg, exp);
            check_value("in_ack during output", in_ack, 32'd0);
            delay = (next_rand() >> 8) % 4;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            out_ack = 1'b1;
            wait_for(sel_out_req, 1'b0, "out_req falling");
            out_ack = 1'b0;
         end
      end
   endtask

   task automatic load_table();
      // LP 1 builds a history, then a straggler, a match and a miss
      stim_tab[0] = {3'd1, 16'd100, 1'b0, 16'd0,  8'h25, 6'd1};
      stim_tab[1] = {3'd1, 16'd200, 1'b0, 16'd0,  8'h43, 6'd1};
      stim_tab[2] = {3'd1, 16'd300, 1'b0, 16'd0,  8'h60, 6'd1};
      stim_tab[3] = {3'd1, 16'd150, 1'b0, 16'd0,  8'h81, 6'd5};
      stim_tab[4] = {3'd1, 16'd150, 1'b1, 16'd0,  8'h00, 6'd1};
      stim_tab[5] = {3'd1, 16'd500, 1'b1, 16'd0,  8'h00, 6'd1};
      // LP 2 prunes below GVT before its straggler
      stim_tab[6] = {3'd2, 16'd50,  1'b0, 16'd0,  8'h00, 6'd1};
      stim_tab[7] = {3'd2, 16'd80,  1'b0, 16'd0,  8'hff, 6'd1};
      stim_tab[8] = {3'd2, 16'd400, 1'b0, 16'd90, 8'h22, 6'd1};
      stim_tab[9] = {3'd2, 16'd45,  1'b0, 16'd40, 8'h05, 6'd3};
   endtask

   initial begin
      stim_t r;
      int    i;
      in_req  = 1'b0;
      in_msg  = '0;
      in_gvt  = '0;
      in_rnd  = '0;
      out_ack = 1'b0;
      rst_n   = 1'b0;
      for (i = 0; i < 8; i++) begin
         hist_cnt[i] = 0;
      end
      load_table();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("in_ack after reset", in_ack, 32'd0);
      check_value("out_req after reset", out_req, 32'd0);
      check_value("busy after reset", busy, 32'd0);

      send_request(stim_tab[0]);
      for (i = 0; i < tab_len && !timed_out; i++) begin
         predict(stim_tab[i]);
         check_value("message count", exp_q.size(), stim_tab[i].n_out);
         take_input();
         if (i + 1 < tab_len) begin
            send_request(stim_tab[i + 1]);   // Next request waits behind the outputs
         end
         collect_outputs();
      end

      // LP 6 overfills its history, then one straggler rolls it all back
      for (i = 0; i <= rand_len && !timed_out; i++) begin
         r.lp      = 3'd6;
         r.ev_time = (i < rand_len) ? 16'(1000 + 50*i) : 16'd999;
         r.ev_type = 1'b0;
         r.gvt     = 16'd0;
         r.rnd     = next_rand() >> 16;
         r.n_out   = '0;
         predict(r);
         send_request(r);
         take_input();
         collect_outputs();
      end

      wait_for(sel_busy, 1'b0, "busy falling after the last event");
      check_value("out_req when idle", out_req, 32'd0);

      $display("Closing: %0d checks, %0d value errors, timeout %0d, %0d assertion failures",
               n_checks, n_errors, timed_out, i_dut.i_checker.fail_count);
      if (n_errors == 0 && !timed_out && i_dut.i_checker.fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== bench/phold_core_checker.sv ====
`timescale 1ns/1ps

module phold_core_checker (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          in_req,
   input  logic                          in_ack,
   input  logic                          out_req,
   input  logic [phold_pkg::msg_w-1:0]   out_msg,
   input  logic                          out_ack
);
   int fail_count = 0;    // Read by the testbench

   // Message held while the consumer has not answered
   assert property (@(posedge clk) disable iff (!rst_n)
      out_req && !out_ack |=> $stable(out_msg))
   else begin
      $error("out_msg changed while out_req waited for out_ack");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      $rose(in_ack) |-> $past(in_req))
   else begin
      $error("in_ack rose without a pending in_req");
      fail_count++;
   end

   // Both handshake outputs idle in reset
   assert property (@(posedge clk) !rst_n |-> !out_req && !in_ack)
   else begin
      $error("out_req or in_ack high during reset");
      fail_count++;
   end

endmodule

bind phold_core phold_core_checker i_checker (.*);

// ==== source/phold_core.sv ====
`timescale 1ns/1ps

module phold_core (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            in_req,
   input  logic [phold_pkg::msg_w-1:0]     in_msg,
   input  logic [phold_pkg::time_w-1:0]    in_gvt,
   input  logic [phold_pkg::rnd_w-1:0]     in_rnd,
   output logic                            in_ack,
   output logic                            out_req,
   output logic [phold_pkg::msg_w-1:0]     out_msg,
   input  logic                            out_ack,
   output logic                            busy
);
   import phold_pkg::*;
   import history_pkg::*;

   logic [lp_id_w-1:0]    rd_lp;
   logic [hist_idx_w-1:0] rd_idx;
   logic [hist_idx_w-1:0] wr_idx;
   logic [msg_w-1:0]      rd_entry;
   logic [msg_w-1:0]      wr_entry;
   logic [hist_cnt_w-1:0] count;
   logic [hist_cnt_w-1:0] new_count;
   logic                  wr_en;
   logic                  set_count;
   logic                  clear;
   logic                  entry_vld;
   logic [time_w-1:0]     cur_time;
   logic [time_w-1:0]     gvt;
   event_type_e           cur_type;
   filter_verdict_e       verdict;
   logic                  discard_cur;
   logic                  cancel_pending;
   logic [msg_w-1:0]      cancel_msg;
   logic                  fifo_flush;
   logic                  keep_wr_en;
   logic                  keep_rd_en;
   logic                  keep_empty;
   logic [msg_w-1:0]      keep_din;
   logic [msg_w-1:0]      keep_dout;
   logic                  rb_wr_en;
   logic                  rb_rd_en;
   logic                  rb_empty;
   logic [msg_w-1:0]      rb_dout;

   phold_sequencer i_sequencer (.*);

   history_store i_store (.*);

   history_filter i_filter (
      .clk, .rst_n, .clear, .entry_vld,
      .entry (rd_entry),
      .cur_time, .cur_type, .gvt, .verdict,
      .discard_cur, .cancel_pending, .cancel_msg
   );

   event_fifo i_keep_fifo (
      .clk, .rst_n,
      .flush (fifo_flush),
      .wr_en (keep_wr_en),
      .din   (keep_din),
      .rd_en (keep_rd_en),
      .dout  (keep_dout),
      .empty (keep_empty)
   );

   // Rolled-back entries come straight from the store read port
   event_fifo i_rollback_fifo (
      .clk, .rst_n,
      .flush (fifo_flush),
      .wr_en (rb_wr_en),
      .din   (rd_entry),
      .rd_en (rb_rd_en),
      .dout  (rb_dout),
      .empty (rb_empty)
   );

endmodule

// ==== source/phold_sequencer.sv ====
`timescale 1ns/1ps

module phold_sequencer (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 in_req,
   input  logic [phold_pkg::msg_w-1:0]          in_msg,
   input  logic [phold_pkg::time_w-1:0]         in_gvt,
   input  logic [phold_pkg::rnd_w-1:0]          in_rnd,
   output logic                                 in_ack,
   output logic                                 out_req,
   output logic [phold_pkg::msg_w-1:0]          out_msg,
   input  logic                                 out_ack,
   output logic                                 busy,
   output logic [phold_pkg::lp_id_w-1:0]        rd_lp,
   output logic [history_pkg::hist_idx_w-1:0]   rd_idx,
   input  logic [phold_pkg::msg_w-1:0]          rd_entry,
   input  logic [history_pkg::hist_cnt_w-1:0]   count,
   output logic                                 wr_en,
   output logic [history_pkg::hist_idx_w-1:0]   wr_idx,
   output logic [phold_pkg::msg_w-1:0]          wr_entry,
   output logic                                 set_count,
   output logic [history_pkg::hist_cnt_w-1:0]   new_count,
   output logic                                 clear,
   output logic                                 entry_vld,
   output logic [phold_pkg::time_w-1:0]         cur_time,
   output phold_pkg::event_type_e               cur_type,
   output logic [phold_pkg::time_w-1:0]         gvt,
   input  history_pkg::filter_verdict_e         verdict,
   input  logic                                 discard_cur,
   input  logic                                 cancel_pending,
   input  logic [phold_pkg::msg_w-1:0]          cancel_msg,
   output logic                                 fifo_flush,
   output logic                                 keep_wr_en,
   output logic [phold_pkg::msg_w-1:0]          keep_din,
   output logic                                 keep_rd_en,
   input  logic [phold_pkg::msg_w-1:0]          keep_dout,
   input  logic                                 keep_empty,
   output logic                                 rb_wr_en,
   output logic                                 rb_rd_en,
   input  logic [phold_pkg::msg_w-1:0]          rb_dout,
   input  logic                                 rb_empty
);
   import phold_pkg::*;
   import history_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_ack,
      st_read,
      st_process,
      st_write,
      st_out_primary,
      st_out_rollback
   } state_e;

   state_e                   state;
   logic [msg_w-1:0]         cur_msg;
   logic [rnd_w-1:0]         rnd;
   logic [lp_id_w-1:0]       cur_lp;
   logic [hist_cnt_w-1:0]    idx;         // Read index, then write index
   logic [hist_cnt_w-1:0]    keep_cnt;
   logic                     rd_vld;
   logic                     reissue;     // Cancellation sent, re-issue next
   logic                     gen_push;
   logic                     out_done;
   logic [hist_offset_w-1:0] gen_offset;
   logic [lp_id_w-1:0]       gen_target;
   logic [msg_w-1:0]         gen_msg;
   logic [msg_w-1:0]         gen_entry;
   logic [msg_w-1:0]         primary_msg;
   logic [time_w-1:0]        rb_time;
   logic [lp_id_w-1:0]       rb_lp;
   logic [lp_id_w-1:0]       rb_target;
   logic [hist_offset_w-1:0] rb_offset;

   assign cur_time = cur_msg[msg_time_lsb +: time_w];
   assign cur_lp   = cur_msg[msg_lp_lsb +: lp_id_w];
   assign cur_type = event_type_e'(cur_msg[msg_type_bit]);

   // Child event at least min_gap later
   assign gen_offset = 8'(min_gap) + {3'b0, rnd[4:0]};
   assign gen_target = rnd[rnd_w-1:5];
   assign gen_msg    = make_msg(ev_regular, gen_target, cur_time + {8'b0, gen_offset});

   always_comb begin
      gen_entry = make_msg(cur_type, cur_lp, cur_time);
      gen_entry[hist_offset_lsb +: hist_offset_w] = gen_offset;
      gen_entry[hist_target_lsb +: lp_id_w]       = gen_target;
   end

   always_comb begin
      if (discard_cur && cancel_pending) begin
         primary_msg = cancel_msg;
      end else if (discard_cur || cur_type == ev_cancel) begin
         primary_msg = make_msg(ev_cancel, '0, '0);   // Null message
      end else begin
         primary_msg = gen_msg;
      end
   end

   assign rb_time   = rb_dout[msg_time_lsb +: time_w];
   assign rb_lp     = rb_dout[msg_lp_lsb +: lp_id_w];
   assign rb_target = rb_dout[hist_target_lsb +: lp_id_w];
   assign rb_offset = rb_dout[hist_offset_lsb +: hist_offset_w];

   assign busy       = (state != st_idle);
   assign fifo_flush = (state == st_ack);
   assign clear      = (state == st_ack);
   assign rd_lp      = cur_lp;
   assign rd_idx     = idx[hist_idx_w-1:0];
   assign entry_vld  = rd_vld;
   assign rb_wr_en   = entry_vld && (verdict == fv_rollback);

   // New entry is dropped when the history is already full
   assign gen_push   = (state == st_process) && (cur_type == ev_regular) && !discard_cur &&
                       (keep_cnt != hist_cnt_w'(hist_depth));
   assign keep_wr_en = (entry_vld && verdict == fv_keep) || gen_push;
   assign keep_din   = (state == st_process) ? gen_entry : rd_entry;

   assign wr_en      = (state == st_write) && !keep_empty;
   assign keep_rd_en = wr_en;
   assign wr_idx     = idx[hist_idx_w-1:0];
   assign wr_entry   = keep_dout;
   assign set_count  = (state == st_write) && keep_empty;
   assign new_count  = keep_cnt;

   assign out_done = !out_req && !out_ack;   // Previous handshake fully closed
   assign rb_rd_en = (state == st_out_rollback) && !reissue && out_done;

   always_ff @(posedge clk) begin
      if (state == st_idle && in_req) begin
         cur_msg <= in_msg;
         gvt     <= in_gvt;
         rnd     <= in_rnd;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         in_ack   <= 1'b0;
         out_req  <= 1'b0;
         out_msg  <= '0;
         idx      <= '0;
         keep_cnt <= '0;
         rd_vld   <= 1'b0;
         reissue  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (in_req) begin
                  in_ack <= 1'b1;
                  state  <= st_ack;
               end
            end
            st_ack: begin
               if (!in_req) begin
                  in_ack   <= 1'b0;
                  idx      <= '0;
                  keep_cnt <= '0;
                  state    <= st_read;
               end
            end
            st_read: begin
               if (entry_vld && verdict == fv_keep) keep_cnt <= keep_cnt + 1'b1;
               if (idx != count) begin
                  rd_vld <= 1'b1;
                  idx    <= idx + 1'b1;
               end else begin
                  rd_vld <= 1'b0;
                  if (!rd_vld) state <= st_process;   // Last entry already filtered
               end
            end
            st_process: begin
               idx <= '0;
               if (gen_push) keep_cnt <= keep_cnt + 1'b1;
               state <= st_write;
            end
            st_write: begin
               if (!keep_empty) begin
                  idx <= idx + 1'b1;
               end else begin
                  out_msg <= primary_msg;
                  out_req <= 1'b1;
                  state   <= st_out_primary;
               end
            end
            st_out_primary, st_out_rollback: begin
               if (out_req && out_ack) begin
                  out_req <= 1'b0;
               end else if (out_done) begin
                  if (state == st_out_rollback && !reissue) begin
                     out_msg <= make_msg(ev_regular, rb_lp, rb_time);
                     reissue <= 1'b1;
                     out_req <= 1'b1;
                  end else if (!rb_empty) begin
                     // Cancel the entry's child first
                     out_msg <= make_msg(ev_cancel, rb_target, rb_time + {8'b0, rb_offset});
                     reissue <= 1'b0;
                     out_req <= 1'b1;
                     state   <= st_out_rollback;
                  end else begin
                     state <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

// ==== source/event_fifo.sv ====
`timescale 1ns/1ps

module event_fifo (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          flush,
   input  logic                          wr_en,
   input  logic [phold_pkg::msg_w-1:0]   din,
   input  logic                          rd_en,
   output logic [phold_pkg::msg_w-1:0]   dout,
   output logic                          empty
);
   import phold_pkg::*;
   import history_pkg::*;

   logic [msg_w-1:0]      mem [0:hist_depth-1];
   logic [hist_idx_w-1:0] wr_ptr;
   logic [hist_idx_w-1:0] rd_ptr;
   logic [hist_cnt_w-1:0] fill;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en && !flush && (fill != hist_cnt_w'(hist_depth));   // Full drops writes
   assign do_rd = rd_en && !flush && !empty;
   assign empty = (fill == '0);
   assign dout  = mem[rd_ptr];         // Head is visible without a read

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd) begin
            fill <= fill + 1'b1;
         end else if (!do_wr && do_rd) begin
            fill <= fill - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

endmodule

// ==== source/history_filter.sv ====
`timescale 1ns/1ps

module history_filter (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 clear,
   input  logic                                 entry_vld,
   input  logic [phold_pkg::msg_w-1:0]          entry,
   input  logic [phold_pkg::time_w-1:0]         cur_time,
   input  phold_pkg::event_type_e               cur_type,
   input  logic [phold_pkg::time_w-1:0]         gvt,
   output history_pkg::filter_verdict_e         verdict,
   output logic                                 discard_cur,
   output logic                                 cancel_pending,
   output logic [phold_pkg::msg_w-1:0]          cancel_msg
);
   import phold_pkg::*;
   import history_pkg::*;

   logic [time_w-1:0]        entry_time;
   event_type_e              entry_type;
   logic [hist_offset_w-1:0] entry_offset;
   logic [lp_id_w-1:0]       entry_target;
   logic                     annihilate;

   assign entry_time   = entry[msg_time_lsb +: time_w];
   assign entry_type   = event_type_e'(entry[msg_type_bit]);
   assign entry_offset = entry[hist_offset_lsb +: hist_offset_w];
   assign entry_target = entry[hist_target_lsb +: lp_id_w];

   // First matching rule wins
   always_comb begin
      if (entry_time < gvt) begin
         verdict = fv_expired;                 // Older than GVT, can never roll back
      end else if (entry_type != cur_type && entry_time == cur_time && !discard_cur) begin
         verdict = fv_annihilate;              // Event and anti-message meet
      end else if (cur_type == ev_regular && entry_type == ev_regular &&
                   entry_time > cur_time) begin
         verdict = fv_rollback;                // Straggler overtook this entry
      end else begin
         verdict = fv_keep;
      end
   end

   assign annihilate = entry_vld && (verdict == fv_annihilate);

   // Only one annihilation per event
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         discard_cur    <= 1'b0;
         cancel_pending <= 1'b0;
      end else if (clear) begin
         discard_cur    <= 1'b0;
         cancel_pending <= 1'b0;
      end else if (annihilate) begin
         discard_cur <= 1'b1;
         if (cur_type == ev_cancel) begin
            cancel_pending <= 1'b1;   // Child of the undone event must be cancelled too
         end
      end
   end

   always_ff @(posedge clk) begin
      if (annihilate && cur_type == ev_cancel) begin
         cancel_msg <= make_msg(ev_cancel, entry_target, entry_time + {8'b0, entry_offset});
      end
   end

endmodule

// ==== source/history_store.sv ====
`timescale 1ns/1ps

module history_store (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [phold_pkg::lp_id_w-1:0]        rd_lp,
   input  logic [history_pkg::hist_idx_w-1:0]   rd_idx,
   output logic [phold_pkg::msg_w-1:0]          rd_entry,
   output logic [history_pkg::hist_cnt_w-1:0]   count,
   input  logic                                 wr_en,
   input  logic [history_pkg::hist_idx_w-1:0]   wr_idx,
   input  logic [phold_pkg::msg_w-1:0]          wr_entry,
   input  logic                                 set_count,
   input  logic [history_pkg::hist_cnt_w-1:0]   new_count
);
   import phold_pkg::*;
   import history_pkg::*;

   logic [msg_w-1:0]      mem [0:lp_num*hist_depth-1];
   logic [hist_cnt_w-1:0] counts [0:lp_num-1];

   assign count = counts[rd_lp];     // Current LP only

   // Entry address is LP times 16 plus index
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[{rd_lp, wr_idx}] <= wr_entry;
      end
      rd_entry <= mem[{rd_lp, rd_idx}];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < lp_num; i++) begin
            counts[i] <= '0;
         end
      end else if (set_count) begin
         counts[rd_lp] <= new_count;
      end
   end

endmodule

// ==== source/history_pkg.sv ====
package history_pkg;

   localparam int hist_depth = 16;    // Entries per LP
   localparam int hist_idx_w = 4;
   localparam int hist_cnt_w = 5;     // Counts 0 to 16

   // Entry = message plus child offset and child target, bit 31 zero
   localparam int hist_offset_lsb = 20;
   localparam int hist_offset_w   = 8;
   localparam int hist_target_lsb = 28;

   typedef enum logic [1:0] {
      fv_keep,
      fv_expired,
      fv_annihilate,
      fv_rollback
   } filter_verdict_e;

endpackage

// ==== source/phold_pkg.sv ====
package phold_pkg;

   localparam int time_w  = 16;       // Event timestamp
   localparam int lp_id_w = 3;
   localparam int lp_num  = 1 << lp_id_w;
   localparam int msg_w   = 32;       // Message and history entry
   localparam int rnd_w   = 8;
   localparam int min_gap = 10;       // Smallest step between an event and its child

   // Message layout, bits 20 to 31 stay zero
   localparam int msg_time_lsb = 0;
   localparam int msg_lp_lsb   = 16;
   localparam int msg_type_bit = 19;

   typedef enum logic {
      ev_regular = 1'b0,
      ev_cancel  = 1'b1
   } event_type_e;

   // Build a message from its three fields
   function automatic logic [msg_w-1:0] make_msg(
      input event_type_e          ev_type,
      input logic [lp_id_w-1:0]   lp,
      input logic [time_w-1:0]    ev_time
   );
      logic [msg_w-1:0] msg;
      msg = '0;
      msg[msg_time_lsb +: time_w] = ev_time;
      msg[msg_lp_lsb +: lp_id_w]  = lp;
      msg[msg_type_bit]           = ev_type;
      return msg;
   endfunction

endpackage
